// File: verilog/sprite_pkg.sv
package sprite_pkg;

	// ------------------------------------------------------------------------
	// sizes
	localparam int NUM_SPRITES  = 32;
	localparam int DESC_REGS    = 8;	// registers per descriptor
	localparam int LINE_PIXELS  = 360;
	localparam int PIXEL_CYCLES = 4;	// clocks per output pixel
	localparam int NUM_BANKS    = 2;

	localparam int LINE_AW = 9;
	localparam int SMEM_AW = 21;	// word address, 2M x 16
	localparam int OFFS_W  = 14;
	localparam int COLOR_W = 6;

	// ------------------------------------------------------------------------
	// encodings
	typedef enum logic [1:0] {
		MODE_OFF  = 2'd0,	// sprite inactive
		MODE_4C   = 2'd1,
		MODE_16C  = 2'd2,
		MODE_TRUE = 2'd3
	} color_mode_e;

	typedef enum logic [3:0] {
		IDLE, READ_ATTR, READ_YPOS, READ_YSIZE, READ_ADDR0, READ_ADDR1,
		READ_ADDR2, READ_XPOS, READ_XSIZE, FETCH, NEXT, DONE
	} engine_state_e;

	typedef struct packed {
		logic [15:0]        word;
		color_mode_e        mode;
		logic [COLOR_W-1:0] pal_base;
		logic [LINE_AW-1:0] start_x;
		logic               load_x;	// first word of a sprite line
	} unpack_cmd_t;

	typedef struct packed {
		logic               we;
		logic [LINE_AW-1:0] addr;
		logic [COLOR_W:0]   pix;	// enable over colour
	} line_wr_t;

endpackage

// File: verilog/sprite_engine.sv
`timescale 1ns/1ns

module sprite_engine (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          line_start,
	input  logic [sprite_pkg::LINE_AW-1:0] vline,
	output logic [7:0]                    desc_addr,
	input  logic [7:0]                    desc_data,
	output logic [sprite_pkg::SMEM_AW-1:0] mem_addr,
	output logic                          mem_req,
	input  logic [15:0]                   mem_data,
	input  logic                          mem_ready,
	output sprite_pkg::unpack_cmd_t       unpack_cmd,
	output logic                          unpack_go,
	input  logic                          unpack_busy,
	output logic                          busy
);
	import sprite_pkg::*;

	localparam int REG_W = $clog2(DESC_REGS);
	localparam int NUM_W = $clog2(NUM_SPRITES);

	engine_state_e      state;
	logic [NUM_W-1:0]   num;	// sprite being walked
	logic [REG_W-1:0]   desc_reg;
	color_mode_e        mode;
	logic [COLOR_W-1:0] pal;
	logic [7:0]         ypos_lo;
	logic               first_line;
	logic [SMEM_AW-1:0] img_addr;
	logic [OFFS_W-1:0]  offs;
	logic [OFFS_W-1:0]  offs_table [NUM_SPRITES];
	logic [LINE_AW-1:0] xpos;
	logic [6:0]         words_left;
	logic [15:0]        word_buf;
	logic               held;	// fetched word waiting for the unpacker
	logic               first_word;
	logic               can_go;
	logic               issue_req;
	logic [LINE_AW-1:0] ypos;
	logic [LINE_AW:0]   y_end;
	logic               visible;
	unpack_cmd_t        next_cmd;

	// register of the descriptor entry read in each state
	always_comb
	begin
		case (state)
			READ_YPOS:  desc_reg = 3'd2;
			READ_YSIZE: desc_reg = 3'd3;
			READ_ADDR0: desc_reg = 3'd5;
			READ_ADDR1: desc_reg = 3'd6;
			READ_ADDR2: desc_reg = 3'd7;
			READ_XPOS:  desc_reg = 3'd0;
			READ_XSIZE: desc_reg = 3'd1;
			default:    desc_reg = 3'd4;	// attr
		endcase
	end

	assign desc_addr = {num, desc_reg};

	// row window ypos .. ypos+ysz-1
	assign ypos    = {desc_data[0], ypos_lo};
	assign y_end   = {1'b0, ypos} + {3'b000, desc_data[7:1]};
	assign visible = (vline >= ypos) && ({1'b0, vline} < y_end);

	assign can_go    = !unpack_busy && !unpack_go;
	assign issue_req = (state == FETCH) && !mem_req && !held && (words_left != 7'd0);

	always_comb
	begin
		next_cmd.word     = held ? word_buf : mem_data;
		next_cmd.mode     = mode;
		next_cmd.pal_base = pal;
		next_cmd.start_x  = xpos;
		next_cmd.load_x   = first_word;
	end

	// offset written back as each word is requested
	always_ff @(posedge clk)
	begin
		if (issue_req && !line_start)
			offs_table[num] <= offs + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= IDLE;
			num       <= '0;
			busy      <= 1'b0;
			mem_req   <= 1'b0;
			unpack_go <= 1'b0;
			held      <= 1'b0;
		end
		else if (line_start)
		begin
			state     <= READ_ATTR;	// restart the walk
			num       <= '0;
			busy      <= 1'b1;
			mem_req   <= 1'b0;
			unpack_go <= 1'b0;
			held      <= 1'b0;
		end
		else
		begin
			unpack_go <= 1'b0;
			case (state)
				READ_ATTR:
				begin
					if (desc_data[7:6] == MODE_OFF)
						state <= NEXT;
					else
					begin
						mode  <= color_mode_e'(desc_data[7:6]);
						pal   <= desc_data[5:0];
						state <= READ_YPOS;
					end
				end
				READ_YPOS:
				begin
					ypos_lo <= desc_data;
					state   <= READ_YSIZE;
				end
				READ_YSIZE:
				begin
					first_line <= (vline == ypos);
					state      <= visible ? READ_ADDR0 : NEXT;
				end
				READ_ADDR0:
				begin
					img_addr[7:0] <= desc_data;
					offs          <= first_line ? '0 : offs_table[num];
					state         <= READ_ADDR1;
				end
				READ_ADDR1:
				begin
					img_addr[15:8] <= desc_data;
					state          <= READ_ADDR2;
				end
				READ_ADDR2:
				begin
					img_addr[SMEM_AW-1:16] <= desc_data[4:0];
					state                  <= READ_XPOS;
				end
				READ_XPOS:
				begin
					xpos[7:0] <= desc_data;
					state     <= READ_XSIZE;
				end
				READ_XSIZE:
				begin
					xpos[8]    <= desc_data[0];
					words_left <= desc_data[7:1];
					first_word <= 1'b1;
					state      <= FETCH;
				end
				FETCH:
				begin
					if (mem_req && mem_ready)
					begin
						mem_req <= 1'b0;
						if (can_go)
						begin
							unpack_cmd <= next_cmd;
							unpack_go  <= 1'b1;
							first_word <= 1'b0;
						end
						else
						begin
							word_buf <= mem_data;
							held     <= 1'b1;
						end
					end
					else if (held)
					begin
						if (can_go)
						begin
							unpack_cmd <= next_cmd;
							unpack_go  <= 1'b1;
							first_word <= 1'b0;
							held       <= 1'b0;
						end
					end
					else if (issue_req)
					begin
						mem_addr   <= img_addr + SMEM_AW'(offs);
						mem_req    <= 1'b1;
						offs       <= offs + 1'b1;
						words_left <= words_left - 1'b1;
					end
					else if (!mem_req)
						state <= NEXT;	// all words of this line sent
				end
				NEXT:
				begin
					if (num == NUM_W'(NUM_SPRITES - 1))
						state <= DONE;
					else
					begin
						num   <= num + 1'b1;
						state <= READ_ATTR;
					end
				end
				DONE:
				begin
					if (can_go)
					begin
						busy  <= 1'b0;	// last word written out
						state <= IDLE;
					end
				end
				default: ;	// idle until line_start
			endcase
		end
	end

endmodule

// File: verilog/pixel_unpack.sv
`timescale 1ns/1ns

module pixel_unpack (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          line_start,
	input  sprite_pkg::unpack_cmd_t       unpack_cmd,
	input  logic                          unpack_go,
	output logic                          unpack_busy,
	output logic [7:0]                    pal_addr,
	input  logic [sprite_pkg::COLOR_W-1:0] pal_data,
	output sprite_pkg::line_wr_t          line_wr
);
	import sprite_pkg::*;

	logic [15:0]        shift_q;	// msb holds the current pixel
	color_mode_e        mode_q;
	logic [COLOR_W-1:0] pal_q;
	logic [LINE_AW-1:0] x_q;
	logic [3:0]         count_q;
	logic [3:0]         pix_count;
	logic               opaque;
	logic [COLOR_W-1:0] colour;

	always_comb
	begin
		case (unpack_cmd.mode)
			MODE_4C:  pix_count = 4'd8;
			MODE_16C: pix_count = 4'd4;
			default:  pix_count = 4'd2;
		endcase
	end

	// true colour unless a palette mode says otherwise
	always_comb
	begin
		pal_addr = {pal_q, shift_q[15:14]};
		opaque   = shift_q[15];
		colour   = shift_q[13:8];
		case (mode_q)
			MODE_4C:
			begin
				opaque = |shift_q[15:14];	// index 0 is see-through
				colour = pal_data;
			end
			MODE_16C:
			begin
				pal_addr = {pal_q[5:2], shift_q[15:12]};
				opaque   = |shift_q[15:12];
				colour   = pal_data;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset || line_start)
		begin
			unpack_busy <= 1'b0;
			line_wr.we  <= 1'b0;
		end
		else
		begin
			// pixels past the right edge are dropped
			line_wr.we   <= unpack_busy && opaque && (x_q < LINE_AW'(LINE_PIXELS));
			line_wr.addr <= x_q;
			line_wr.pix  <= {1'b1, colour};
			if (unpack_go)
			begin
				shift_q     <= unpack_cmd.word;
				mode_q      <= unpack_cmd.mode;
				pal_q       <= unpack_cmd.pal_base;
				count_q     <= pix_count;
				unpack_busy <= 1'b1;
				if (unpack_cmd.load_x)
					x_q <= unpack_cmd.start_x;
			end
			else if (unpack_busy)
			begin
				case (mode_q)
					MODE_4C:  shift_q <= {shift_q[13:0], 2'b00};
					MODE_16C: shift_q <= {shift_q[11:0], 4'b0000};
					default:  shift_q <= {shift_q[7:0], 8'h00};
				endcase
				x_q     <= x_q + 1'b1;
				count_q <= count_q - 1'b1;
				if (count_q == 4'd1)
					unpack_busy <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/line_bank.sv
`timescale 1ns/1ns

module line_bank #(
	parameter int BANK_INDEX = 0
) (
	input  logic                          clk,
	input  logic                          render_bank,
	input  sprite_pkg::line_wr_t          line_wr,
	input  logic [sprite_pkg::LINE_AW-1:0] read_addr,
	input  logic                          clear_we,
	output logic [sprite_pkg::COLOR_W:0]  read_data
);
	import sprite_pkg::*;

	logic [COLOR_W:0]   mem [LINE_PIXELS];
	logic               wr_en;
	logic [LINE_AW-1:0] wr_addr;
	logic [COLOR_W:0]   wr_data;

	// render writes while this bank renders, clears while it is displayed
	always_comb
	begin
		if (render_bank == 1'(BANK_INDEX))
		begin
			wr_en   = line_wr.we;
			wr_addr = line_wr.addr;
			wr_data = line_wr.pix;
		end
		else
		begin
			wr_en   = clear_we;
			wr_addr = read_addr;
			wr_data = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	assign read_data = (read_addr < LINE_AW'(LINE_PIXELS)) ? mem[read_addr] : '0;

endmodule

// File: verilog/line_scanout.sv
`timescale 1ns/1ns

module line_scanout (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic                                              line_start,
	input  logic                                              pre_vline,
	input  logic [sprite_pkg::NUM_BANKS-1:0][sprite_pkg::COLOR_W:0] bank_data,
	output logic [sprite_pkg::LINE_AW-1:0]                     vline,
	output logic                                              render_bank,
	output logic [sprite_pkg::LINE_AW-1:0]                     read_addr,
	output logic                                              clear_we,
	output logic [5:0]                                        spixel,
	output logic                                              spx_en
);
	import sprite_pkg::*;

	localparam int PH_W = $clog2(PIXEL_CYCLES);

	logic [PH_W-1:0]  phase;
	logic             active;
	logic [COLOR_W:0] disp_data;

	assign disp_data = bank_data[~render_bank];	// display is the other bank
	assign clear_we  = active && (phase == PH_W'(1));

	// ------------------------------------------------------------------------
	// line counter and 4-clock pixel sequencer
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vline       <= '0;
			render_bank <= 1'b0;
			read_addr   <= '0;
			phase       <= '0;
			active      <= 1'b0;
			spx_en      <= 1'b0;
		end
		else if (line_start)
		begin
			if (pre_vline)
			begin
				vline       <= '0;
				render_bank <= 1'b0;
			end
			else
			begin
				vline       <= vline + 1'b1;
				render_bank <= ~render_bank;
			end
			read_addr <= '0;
			phase     <= PH_W'(PIXEL_CYCLES - 1);	// one spare clock before pixel 0
			active    <= 1'b1;
			spx_en    <= 1'b0;
		end
		else if (active)
		begin
			phase <= phase + 1'b1;
			case (phase)
				PH_W'(0):
				begin
					if (read_addr == LINE_AW'(LINE_PIXELS))
					begin
						active <= 1'b0;	// line finished
						spx_en <= 1'b0;
					end
					else
					begin
						spixel <= disp_data[COLOR_W-1:0];
						spx_en <= disp_data[COLOR_W];
					end
				end
				PH_W'(2): read_addr <= read_addr + 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/sprite_top.sv
`timescale 1ns/1ns

module sprite_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          line_start,
	input  logic                          pre_vline,
	output logic [7:0]                    desc_addr,
	input  logic [7:0]                    desc_data,
	output logic [7:0]                    pal_addr,
	input  logic [sprite_pkg::COLOR_W-1:0] pal_data,
	output logic [sprite_pkg::SMEM_AW-1:0] mem_addr,
	output logic                          mem_req,
	input  logic [15:0]                   mem_data,
	input  logic                          mem_ready,
	output logic [5:0]                    spixel,
	output logic                          spx_en,
	output logic                          busy
);
	import sprite_pkg::*;

	logic [LINE_AW-1:0] vline;
	logic [LINE_AW-1:0] read_addr;
	logic               render_bank;
	logic               clear_we;
	unpack_cmd_t        unpack_cmd;
	logic               unpack_go;
	logic               unpack_busy;
	line_wr_t           line_wr;
	logic [NUM_BANKS-1:0][COLOR_W:0] bank_data;

	sprite_engine u_engine (
		.clk(clk), .reset(reset), .line_start(line_start), .vline(vline),
		.desc_addr(desc_addr), .desc_data(desc_data),
		.mem_addr(mem_addr), .mem_req(mem_req), .mem_data(mem_data), .mem_ready(mem_ready),
		.unpack_cmd(unpack_cmd), .unpack_go(unpack_go), .unpack_busy(unpack_busy),
		.busy(busy)
	);

	pixel_unpack u_unpack (
		.clk(clk), .reset(reset), .line_start(line_start),
		.unpack_cmd(unpack_cmd), .unpack_go(unpack_go), .unpack_busy(unpack_busy),
		.pal_addr(pal_addr), .pal_data(pal_data), .line_wr(line_wr)
	);

	// one renders while the other is scanned out
	genvar i;
	for (i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		line_bank #(.BANK_INDEX(i)) u_bank (
			.clk(clk), .render_bank(render_bank), .line_wr(line_wr),
			.read_addr(read_addr), .clear_we(clear_we), .read_data(bank_data[i])
		);
	end

	line_scanout u_scanout (
		.clk(clk), .reset(reset), .line_start(line_start), .pre_vline(pre_vline),
		.bank_data(bank_data), .vline(vline), .render_bank(render_bank),
		.read_addr(read_addr), .clear_we(clear_we), .spixel(spixel), .spx_en(spx_en)
	);

endmodule

// File: dv/sprite_tb.sv
`timescale 1ns/1ns

module sprite_tb;
	import sprite_pkg::*;

	localparam int LINE_CYCLES = 1448;	// one raster line, room for the full scanout

	logic                   clk;
	logic                   reset;
	logic                   line_start;
	logic                   pre_vline;
	logic [7:0]             desc_addr;
	logic [7:0]             desc_data;
	logic [7:0]             pal_addr;
	logic [COLOR_W-1:0]     pal_data;
	logic [SMEM_AW-1:0]     mem_addr;
	logic                   mem_req;
	logic [15:0]            mem_data;
	logic                   mem_ready;
	logic [5:0]             spixel;
	logic                   spx_en;
	logic                   busy;

	logic [7:0]             desc_mem [256];
	logic [COLOR_W-1:0]     pal_mem [256];
	logic [15:0]            smem [4096];
	logic [6:0]             exp_line [LINE_PIXELS];
	logic [31:0]            rng;
	logic                   waiting;
	logic [3:0]             wait_cnt;
	int                     test_errors;
	int                     total_errors;
	int                     tests_run;
	int                     tests_failed;

	sprite_top UUT (
		.clk(clk), .reset(reset), .line_start(line_start), .pre_vline(pre_vline),
		.desc_addr(desc_addr), .desc_data(desc_data), .pal_addr(pal_addr),
		.pal_data(pal_data), .mem_addr(mem_addr), .mem_req(mem_req),
		.mem_data(mem_data), .mem_ready(mem_ready), .spixel(spixel),
		.spx_en(spx_en), .busy(busy)
	);

	always #4 clk = ~clk;

	// asynchronous table models
	assign desc_data = desc_mem[desc_addr];
	assign pal_data  = pal_mem[pal_addr];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ------------------------------------------------------------------------
	// sprite memory responder, 1 to 8 cycles of latency
	always @(posedge clk)
	begin
		mem_ready <= 1'b0;
		if (reset || !mem_req)
			waiting <= 1'b0;
		else if (!mem_ready)
		begin
			if (!waiting)
			begin
				rng = xorshift(rng);
				waiting  <= 1'b1;
				wait_cnt <= 4'(rng[2:0]) + 4'd1;
			end
			else if (wait_cnt == 4'd1)
			begin
				mem_ready <= 1'b1;
				mem_data  <= smem[mem_addr[11:0]];	// upper bits ignored
				waiting   <= 1'b0;
			end
			else
				wait_cnt <= wait_cnt - 4'd1;
		end
	end

	task automatic set_sprite(input int n, input logic [1:0] mode, input logic [5:0] pal,
		input int x, input int xsz, input int y, input int ysz, input int addr);
		desc_mem[n*8 + 0] = 8'(x);
		desc_mem[n*8 + 1] = {7'(xsz), 1'(x >> 8)};
		desc_mem[n*8 + 2] = 8'(y);
		desc_mem[n*8 + 3] = {7'(ysz), 1'(y >> 8)};
		desc_mem[n*8 + 4] = {mode, pal};
		desc_mem[n*8 + 5] = 8'(addr);
		desc_mem[n*8 + 6] = 8'(addr >> 8);
		desc_mem[n*8 + 7] = {3'b000, 5'(addr >> 16)};
	endtask

	// expected line v, painted in sprite order
	task automatic paint_expected(input int v);
		int n, w, p, x, ppw, ypos, ysz, xpos, xsz, addr;
		logic [1:0]  mode;
		logic [5:0]  pbase;
		logic [15:0] word;
		logic [7:0]  idx;
		logic [7:0]  tc;
		for (x = 0; x < LINE_PIXELS; x++)
			exp_line[x] = '0;
		for (n = 0; n < NUM_SPRITES; n++)
		begin
			mode  = desc_mem[n*8 + 4][7:6];
			pbase = desc_mem[n*8 + 4][5:0];
			xpos  = {desc_mem[n*8 + 1][0], desc_mem[n*8 + 0]};
			xsz   = desc_mem[n*8 + 1][7:1];
			ypos  = {desc_mem[n*8 + 3][0], desc_mem[n*8 + 2]};
			ysz   = desc_mem[n*8 + 3][7:1];
			addr  = {desc_mem[n*8 + 7][4:0], desc_mem[n*8 + 6], desc_mem[n*8 + 5]};
			ppw   = (mode == 2'd1) ? 8 : (mode == 2'd2) ? 4 : 2;
			if (mode != 2'd0 && v >= ypos && v < ypos + ysz)
			begin
				for (w = 0; w < xsz; w++)
				begin
					word = smem[(addr + (v - ypos) * xsz + w) & 12'hfff];
					for (p = 0; p < ppw; p++)
					begin
						x = xpos + w * ppw + p;
						if (mode == 2'd1)
						begin
							idx = {pbase, word[15 - 2*p -: 2]};
							if (idx[1:0] != 0 && x < LINE_PIXELS)
								exp_line[x] = {1'b1, pal_mem[idx]};
						end
						else if (mode == 2'd2)
						begin
							idx = {pbase[5:2], word[15 - 4*p -: 4]};
							if (idx[3:0] != 0 && x < LINE_PIXELS)
								exp_line[x] = {1'b1, pal_mem[idx]};
						end
						else
						begin
							tc = word[15 - 8*p -: 8];	// enable, spare, colour
							if (tc[7] && x < LINE_PIXELS)
								exp_line[x] = {1'b1, tc[5:0]};
						end
					end
				end
			end
		end
	endtask

	// one line period; with check set, the displayed line is compared with line v
	task automatic run_line(input logic pre, input logic check, input int v,
		input string name);
		int cyc;
		int k;
		logic busy_fell;
		logic [6:0] got;
		if (check)
			paint_expected(v);
		busy_fell = 1'b0;
		@(posedge clk);
		line_start <= 1'b1;
		pre_vline  <= pre;
		@(posedge clk);	// strobe sampled here
		line_start <= 1'b0;
		pre_vline  <= 1'b0;
		for (cyc = 1; cyc <= LINE_CYCLES; cyc++)
		begin
			@(posedge clk);
			#1;
			if (cyc == 1 && busy !== 1'b1)
			begin
				test_errors++;
				$display("test %s: busy did not rise after line_start", name);
			end
			if (!busy)
				busy_fell = 1'b1;
			if (check && cyc >= 2 && (cyc - 2) % 4 == 0 && (cyc - 2) / 4 < LINE_PIXELS)
			begin
				k   = (cyc - 2) / 4;
				got = {spx_en, spx_en ? spixel : 6'd0};
				if (got !== exp_line[k])
				begin
					test_errors++;
					if (test_errors <= 10)
						$display("ERROR test %s line %0d pixel %0d expected %h actual %h",
							name, v, k, exp_line[k], got);
				end
			end
		end
		if (!busy_fell)
		begin
			test_errors++;
			$display("test %s: busy never fell within a line period", name);
		end
	endtask

	// empty table, two lines so both banks get scanned out and cleared
	task automatic clean_banks(input string name);
		int i;
		for (i = 0; i < 256; i++)
			desc_mem[i] = 8'h00;
		run_line(1'b0, 1'b0, 0, name);
		run_line(1'b0, 1'b0, 0, name);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
			test_errors);
		test_errors = 0;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	task automatic test_reset_idle();
		if (busy !== 1'b0 || mem_req !== 1'b0 || spx_en !== 1'b0)
		begin
			test_errors++;
			$display("ERROR test reset_idle busy mem_req spx_en expected 000 actual %b%b%b",
				busy, mem_req, spx_en);
		end
		clean_banks("reset_idle");
		run_line(1'b1, 1'b0, 0, "reset_idle");
		run_line(1'b0, 1'b1, 0, "reset_idle");
		finish_test("reset_idle");
	endtask

	task automatic test_palette16();
		clean_banks("palette16");
		set_sprite(5, 2'd2, 6'h14, 10, 2, 0, 1, 'h100);
		smem[12'h100] = 16'h1203;	// index 0 leaves a gap
		smem[12'h101] = 16'h0a0f;
		run_line(1'b1, 1'b0, 0, "palette16");
		run_line(1'b0, 1'b1, 0, "palette16");
		finish_test("palette16");
	endtask

	task automatic test_modes();
		clean_banks("modes");
		set_sprite(1, 2'd1, 6'h09, 100, 2, 0, 1, 'h200);
		set_sprite(2, 2'd3, 6'h00, 300, 3, 0, 1, 'h300);
		smem[12'h200] = 16'he41b;
		smem[12'h201] = 16'h9c30;
		smem[12'h300] = 16'h8a3f;
		smem[12'h301] = 16'h00bf;
		smem[12'h302] = 16'hc1ff;
		run_line(1'b1, 1'b0, 0, "modes");
		run_line(1'b0, 1'b1, 0, "modes");
		finish_test("modes");
	endtask

	task automatic test_tall_sprite();
		int v;
		clean_banks("tall_sprite");
		set_sprite(9, 2'd2, 6'h20, 40, 3, 3, 4, 'h600);
		run_line(1'b1, 1'b0, 0, "tall_sprite");
		for (v = 0; v < 8; v++)
			run_line(1'b0, 1'b1, v, "tall_sprite");	// rows advance line by line
		finish_test("tall_sprite");
	endtask

	task automatic test_overlap();
		clean_banks("overlap");
		set_sprite(3, 2'd2, 6'h2c, 50, 4, 0, 1, 'h400);
		set_sprite(7, 2'd1, 6'h11, 56, 2, 0, 1, 'h500);
		set_sprite(12, 2'd3, 6'h00, 60, 4, 0, 1, 'h700);
		run_line(1'b1, 1'b0, 0, "overlap");
		run_line(1'b0, 1'b1, 0, "overlap");
		finish_test("overlap");
	endtask

	initial
	begin
		int i;
		clk          = 1'b0;
		reset        = 1'b1;
		line_start   = 1'b0;
		pre_vline    = 1'b0;
		mem_ready    = 1'b0;
		mem_data     = 16'h0000;
		rng          = 32'd8524;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (i = 0; i < 256; i++)
		begin
			desc_mem[i] = 8'h00;
			pal_mem[i]  = 6'((i * 7) ^ (i >> 3));
		end
		for (i = 0; i < 4096; i++)
			smem[i] = 16'((i * 40503) ^ (i << 7) ^ (i >> 5));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		#1;
		test_reset_idle();
		test_palette16();
		test_modes();
		test_tall_sprite();
		test_overlap();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
verilog/sprite_pkg.sv
verilog/sprite_engine.sv
verilog/pixel_unpack.sv
verilog/line_bank.sv
verilog/line_scanout.sv
verilog/sprite_top.sv
dv/sprite_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sprite processor testbench with Verilator
set -e

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module sprite_tb -o sprite_sim
./obj_dir/sprite_sim > sim.log 2>&1 || true
cat sim.log

# the log decides pass or fail
grep -q "TEST RESULT: PASS" sim.log
